// File: tb/swu_vectors.txt
// frame lines: one pixel each, channel 0 word then channel 1 word
// after each frame: expected output word count, 16-bit sum of output words
10 11
12 13
14 15
16 17
18 19
1a 1b
1c 1d
1e 1f
20 21
22 23
24 25
26 27
28 29
2a 2b
2c 2d
2e 2f
0048 08dc
ff fe
fd fc
fb fa
f9 f8
f7 f6
f5 f4
f3 f2
f1 f0
ef ee
ed ec
eb ea
e9 e8
e7 e6
e5 e4
e3 e2
e1 e0
0048 435c

// File: sim.f
logic/swu_pkg.sv
logic/swu_req_if.sv
logic/swu_pixel_writer.sv
logic/swu_line_buffer.sv
logic/swu_window_walker.sv
logic/swu_read_stage.sv
logic/swu_top.sv
tb/swu_props.sv
tb/tb_swu.sv

// File: Makefile
# Verilator build and run for the sliding-window unit

VERILATOR ?= verilator
TOP       ?= tb_swu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= >>> FAIL
PASS_MSG  ?= >>> PASS

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '$(PASS_MSG)' $(LOG); then echo "no pass result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_swu.sv
`timescale 1ns/1ps

module tb_swu;
   import swu_pkg::*;

   localparam int FRAMES      = 3;
   localparam int SEED        = 8082;
   localparam int TIMEOUT_K   = 8;
   localparam int MAX_CYCLES  = FRAMES * (FRAME_WORDS + OUT_WORDS) * TIMEOUT_K;
   // each frame in the vectors file: input words, then count and sum
   localparam int VEC_STRIDE  = FRAME_WORDS + 2;
   localparam int VEC_ENTRIES = 2 * VEC_STRIDE;

   logic              clk;
   logic              resetn;
   logic [WORD_W-1:0] s_data_i;
   logic              s_valid_i;
   logic              s_ready_o;
   logic [WORD_W-1:0] m_data_o;
   logic              m_valid_o;
   logic              m_ready_i;
   logic              m_last_o;

   logic [15:0]       vec_mem [VEC_ENTRIES];
   logic [WORD_W-1:0] frame_words [FRAME_WORDS];
   logic [WORD_W-1:0] exp_q [$];
   logic [31:0]       rng;
   int                cycles;
   int                checks;
   int                errors;
   int                tests;

   swu_top UUT (
      .clk       (clk),
      .resetn    (resetn),
      .s_data_i  (s_data_i),
      .s_valid_i (s_valid_i),
      .s_ready_o (s_ready_o),
      .m_data_o  (m_data_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i),
      .m_last_o  (m_last_o)
   );

   always #20 clk = ~clk;

   initial begin : watchdog
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      $display("timeout: the frames did not finish within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   ////////////////////
   // compare tasks

   task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, want);
      end
   endtask

   task automatic check_total(input string name, input int got, input int want);
      checks++;
      if (got != want) begin
         errors++;
         $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, want);
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      tests++;
      if (errors == err_start) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d errors", tests, name, errors - err_start);
      end
   endtask

   ////////////////////
   // reference model

   task automatic load_frame(input int f);
      for (int i = 0; i < FRAME_WORDS; i++) begin
         frame_words[i] = vec_mem[f * VEC_STRIDE + i][WORD_W-1:0];
      end
   endtask

   task automatic random_frame();
      for (int i = 0; i < FRAME_WORDS; i++) begin
         rng = xorshift(rng);
         frame_words[i] = rng[15:8];
      end
   endtask

   // walk order: output row, output column, kernel row, kernel column, channel
   task automatic build_model();
      exp_q.delete();
      for (int r = 0; r < OFM_H; r++) begin
         for (int c = 0; c < OFM_W; c++) begin
            for (int kh = 0; kh < KERNEL; kh++) begin
               for (int kw = 0; kw < KERNEL; kw++) begin
                  for (int ch = 0; ch < EFF_CH; ch++) begin
                     exp_q.push_back(frame_words[((r + kh) * IFM_W + c + kw) * EFF_CH + ch]);
                  end
               end
            end
         end
      end
   endtask

   function automatic logic [15:0] queue_sum();
      logic [15:0] sum;
      sum = '0;
      foreach (exp_q[i]) begin
         sum = sum + 16'(exp_q[i]);
      end
      return sum;
   endfunction

   ////////////////////
   // one frame in, one frame out

   task automatic run_frame(input string name, input bit in_gaps, input bit out_gaps,
                            input int exp_count, input logic [15:0] exp_sum);
      int                in_pos;
      int                out_cnt;
      int                err_start;
      bit                held;
      bit                done;
      logic [15:0]       sum;
      logic [WORD_W-1:0] want;
      in_pos    = 0;
      out_cnt   = 0;
      held      = 1'b0;
      done      = 1'b0;
      sum       = '0;
      err_start = errors;
      while (!done) begin
         @(negedge clk);
         // a presented word keeps valid and data until it is taken
         if (in_pos < FRAME_WORDS) begin
            if (!held) begin
               rng = xorshift(rng);
               s_valid_i = !in_gaps || (rng[2:0] > 3'd2);
               s_data_i  = frame_words[in_pos];
            end
            held = s_valid_i && !s_ready_o;
            if (s_valid_i && s_ready_o) begin
               in_pos++;
            end
         end else begin
            s_valid_i = 1'b0;
         end
         rng = xorshift(rng);
         m_ready_i = !out_gaps || rng[5];
         if (m_valid_o && m_ready_i) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("output word %0d arrived after the expected end of frame", out_cnt);
            end else begin
               want = exp_q.pop_front();
               check_word("m_data_o", m_data_o, want);
               check_flag("m_last_o", m_last_o, exp_q.size() == 0);
            end
            sum  = sum + 16'(m_data_o);
            done = m_last_o;
            out_cnt++;
         end
      end
      check_total("output word count", out_cnt, exp_count);
      check_total("output word sum", int'(sum), int'(exp_sum));
      report_test(name, err_start);
   endtask

   initial begin : main
      int err_start;
      clk       = 1'b0;
      resetn    = 1'b0;
      s_data_i  = '0;
      s_valid_i = 1'b0;
      m_ready_i = 1'b0;
      rng       = SEED;
      checks    = 0;
      errors    = 0;
      tests     = 0;
      $readmemh("tb/swu_vectors.txt", vec_mem);
      repeat (16) @(negedge clk);
      resetn = 1'b1;

      @(negedge clk);
      err_start = errors;
      check_flag("m_valid_o", m_valid_o, 1'b0);
      check_flag("s_ready_o", s_ready_o, 1'b1);
      report_test("state after reset", err_start);

      load_frame(0);
      build_model();
      run_frame("frame 1 free flow", 1'b0, 1'b0,
                int'(vec_mem[FRAME_WORDS]), vec_mem[FRAME_WORDS + 1]);
      load_frame(1);
      build_model();
      run_frame("frame 2 output back-pressure", 1'b0, 1'b1,
                int'(vec_mem[VEC_STRIDE + FRAME_WORDS]), vec_mem[VEC_STRIDE + FRAME_WORDS + 1]);
      random_frame();
      build_model();
      run_frame("frame 3 random with input gaps", 1'b1, 1'b1, OUT_WORDS, queue_sum());

      // nothing may follow the last frame
      err_start = errors;
      repeat (8) begin
         @(negedge clk);
         m_ready_i = 1'b1;
         check_flag("m_valid_o", m_valid_o, 1'b0);
      end
      check_flag("s_ready_o", s_ready_o, 1'b1);
      report_test("idle after last frame", err_start);

      if (UUT.u_props.fail_count != 0) begin
         $display("%0d assertion failures in the bound properties", UUT.u_props.fail_count);
         errors += UUT.u_props.fail_count;
      end
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: tb/swu_props.sv
`timescale 1ns/1ps

module swu_props (
   input logic                       clk,
   input logic                       resetn,
   input logic [swu_pkg::WORD_W-1:0] m_data_i,
   input logic                       m_valid_i,
   input logic                       m_ready_i,
   input logic                       m_last_i,
   input logic                       s_ready_i,
   input logic [swu_pkg::IDX_W-1:0]  wr_count_i,
   input logic [swu_pkg::IDX_W-1:0]  release_base_i
);
   import swu_pkg::*;

   // failures seen so far, read back by the testbench
   int fail_count = 0;

   logic [IDX_W-1:0] occupancy;

   assign occupancy = wr_count_i - release_base_i;

   // stalled output word holds
   a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
      (m_valid_i && !m_ready_i) |=> (m_valid_i && $stable(m_data_i) && $stable(m_last_i)))
      else begin
         $error("output word or last flag changed while stalled");
         fail_count++;
      end

   a_last_valid: assert property (@(posedge clk) disable iff (!resetn)
      m_last_i |-> m_valid_i)
      else begin
         $error("m_last_o high without m_valid_o");
         fail_count++;
      end

   // full buffer blocks the input
   a_full_block: assert property (@(posedge clk) disable iff (!resetn)
      (occupancy == IDX_W'(BUF_DEPTH)) |-> !s_ready_i)
      else begin
         $error("s_ready_o high with a full line buffer");
         fail_count++;
      end

endmodule

bind swu_top swu_props u_props (
   .clk            (clk),
   .resetn         (resetn),
   .m_data_i       (m_data_o),
   .m_valid_i      (m_valid_o),
   .m_ready_i      (m_ready_i),
   .m_last_i       (m_last_o),
   .s_ready_i      (s_ready_o),
   .wr_count_i     (wr_count),
   .release_base_i (release_base)
);

// File: logic/swu_top.sv
`timescale 1ns/1ps

module swu_top (
   input  logic                        clk,
   input  logic                        resetn,
   input  logic [swu_pkg::WORD_W-1:0]  s_data_i,
   input  logic                        s_valid_i,
   output logic                        s_ready_o,
   output logic [swu_pkg::WORD_W-1:0]  m_data_o,
   output logic                        m_valid_o,
   input  logic                        m_ready_i,
   output logic                        m_last_o
);
   import swu_pkg::*;

   // writer and walker bookkeeping
   logic [IDX_W-1:0]  wr_count;
   logic [IDX_W-1:0]  release_base;
   logic              frame_done;

   ////////////////////
   // buffer ports

   logic              wr_en;
   logic [BUF_AW-1:0] wr_addr;
   logic [WORD_W-1:0] wr_data;
   logic              rd_en;
   logic [BUF_AW-1:0] rd_addr;
   logic [WORD_W-1:0] rd_data;

   swu_req_if req_bus ();

   swu_pixel_writer u_writer (
      .clk            (clk),
      .resetn         (resetn),
      .s_data_i       (s_data_i),
      .s_valid_i      (s_valid_i),
      .s_ready_o      (s_ready_o),
      .release_base_i (release_base),
      .frame_done_i   (frame_done),
      .wr_count_o     (wr_count),
      .wr_en_o        (wr_en),
      .wr_addr_o      (wr_addr),
      .wr_data_o      (wr_data)
   );

   swu_line_buffer u_buffer (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   swu_window_walker u_walker (
      .clk            (clk),
      .resetn         (resetn),
      .wr_count_i     (wr_count),
      .release_base_o (release_base),
      .frame_done_o   (frame_done),
      .req            (req_bus.walker)
   );

   swu_read_stage u_reader (
      .clk       (clk),
      .resetn    (resetn),
      .req       (req_bus.reader),
      .rd_en_o   (rd_en),
      .rd_addr_o (rd_addr),
      .rd_data_i (rd_data),
      .m_data_o  (m_data_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i),
      .m_last_o  (m_last_o)
   );

endmodule

// File: logic/swu_read_stage.sv
`timescale 1ns/1ps

module swu_read_stage (
   input  logic                        clk,
   input  logic                        resetn,
   swu_req_if.reader                   req,
   output logic                        rd_en_o,
   output logic [swu_pkg::BUF_AW-1:0]  rd_addr_o,
   input  logic [swu_pkg::WORD_W-1:0]  rd_data_i,
   output logic [swu_pkg::WORD_W-1:0]  m_data_o,
   output logic                        m_valid_o,
   input  logic                        m_ready_i,
   output logic                        m_last_o
);

   // entry 0 sits in the RAM read register, entry 1 in the output register
   logic rd_valid;
   logic rd_last;
   logic out_valid;
   logic out_last;
   logic [$bits(m_data_o)-1:0] out_data;

   logic out_free;
   logic accept;

   // output entry empty or being taken this cycle
   assign out_free = !out_valid || m_ready_i;

   assign req.req_ready = !rd_valid || out_free;
   assign accept        = req.req_valid && req.req_ready;

   assign rd_en_o   = accept;
   assign rd_addr_o = req.req_addr;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_valid  <= 1'b0;
         rd_last   <= 1'b0;
         out_valid <= 1'b0;
         out_last  <= 1'b0;
      end else begin
         if (req.req_ready) begin
            rd_valid <= accept;
            rd_last  <= accept && req.req_last;
         end
         if (out_free) begin
            out_valid <= rd_valid;
            out_last  <= rd_valid && rd_last;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (out_free && rd_valid) begin
         out_data <= rd_data_i;
      end
   end

   assign m_data_o  = out_data;
   assign m_valid_o = out_valid;
   assign m_last_o  = out_last;

endmodule

// File: logic/swu_window_walker.sv
`timescale 1ns/1ps

module swu_window_walker (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic [swu_pkg::IDX_W-1:0]  wr_count_i,
   output logic [swu_pkg::IDX_W-1:0]  release_base_o,
   output logic                       frame_done_o,
   swu_req_if.walker                  req
);
   import swu_pkg::*;

   // trackers, innermost first
   logic [$clog2(EFF_CH)-1:0] ch;
   logic [$clog2(KERNEL)-1:0] kw;
   logic [$clog2(KERNEL)-1:0] kh;
   logic [$clog2(OFM_W)-1:0]  oc;
   logic [$clog2(OFM_H)-1:0]  orow;

   logic ch_end;
   logic kw_end;
   logic kh_end;
   logic oc_end;
   logic or_end;

   logic [IDX_W-1:0] pos_base;
   logic [IDX_W-1:0] win_off;
   logic [IDX_W-1:0] elem_idx;
   logic             accept;

   assign ch_end = (ch == EFF_CH - 1);
   assign kw_end = (kw == KERNEL - 1);
   assign kh_end = (kh == KERNEL - 1);
   assign oc_end = (oc == OFM_W - 1);
   assign or_end = (orow == OFM_H - 1);

   ////////////////////
   // element index

   // first input word of the current output position
   assign pos_base = IDX_W'((orow * IFM_W + oc) * EFF_CH);
   assign win_off  = IDX_W'((kh * IFM_W + kw) * EFF_CH + ch);
   assign elem_idx = pos_base + win_off;

   // index never reaches 2*BUF_DEPTH, one subtraction is enough for the mod
   always_comb begin
      if (elem_idx >= BUF_DEPTH) begin
         req.req_addr = BUF_AW'(elem_idx - BUF_DEPTH);
      end else begin
         req.req_addr = BUF_AW'(elem_idx);
      end
   end

   // word is present once its index has been written
   assign req.req_valid = (elem_idx < wr_count_i);
   assign req.req_last  = ch_end && kw_end && kh_end && oc_end && or_end;

   assign accept       = req.req_valid && req.req_ready;
   assign frame_done_o = accept && req.req_last;

   // everything below this position may be overwritten
   assign release_base_o = pos_base;

   ////////////////////
   // tracker stepping

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch   <= '0;
         kw   <= '0;
         kh   <= '0;
         oc   <= '0;
         orow <= '0;
      end else if (accept) begin
         if (!ch_end) begin
            ch <= ch + 1'b1;
         end else begin
            ch <= '0;
            if (!kw_end) begin
               kw <= kw + 1'b1;
            end else begin
               kw <= '0;
               if (!kh_end) begin
                  kh <= kh + 1'b1;
               end else begin
                  kh <= '0;
                  if (!oc_end) begin
                     oc <= oc + 1'b1;
                  end else begin
                     oc <= '0;
                     // last row wraps to zero, ready for the next frame
                     if (!or_end) begin
                        orow <= orow + 1'b1;
                     end else begin
                        orow <= '0;
                     end
                  end
               end
            end
         end
      end
   end

endmodule

// File: logic/swu_line_buffer.sv
`timescale 1ns/1ps

module swu_line_buffer (
   input  logic                        clk,
   input  logic                        wr_en_i,
   input  logic [swu_pkg::BUF_AW-1:0]  wr_addr_i,
   input  logic [swu_pkg::WORD_W-1:0]  wr_data_i,
   input  logic                        rd_en_i,
   input  logic [swu_pkg::BUF_AW-1:0]  rd_addr_i,
   output logic [swu_pkg::WORD_W-1:0]  rd_data_o
);
   import swu_pkg::*;

   logic [WORD_W-1:0] mem [BUF_DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read register only loads on rd_en_i so a stalled read keeps its word
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// File: logic/swu_pixel_writer.sv
`timescale 1ns/1ps

module swu_pixel_writer (
   input  logic                        clk,
   input  logic                        resetn,
   input  logic [swu_pkg::WORD_W-1:0]  s_data_i,
   input  logic                        s_valid_i,
   output logic                        s_ready_o,
   input  logic [swu_pkg::IDX_W-1:0]   release_base_i,
   input  logic                        frame_done_i,
   output logic [swu_pkg::IDX_W-1:0]   wr_count_o,
   output logic                        wr_en_o,
   output logic [swu_pkg::BUF_AW-1:0]  wr_addr_o,
   output logic [swu_pkg::WORD_W-1:0]  wr_data_o
);
   import swu_pkg::*;

   logic [IDX_W-1:0]  wr_count;
   logic [BUF_AW-1:0] wr_ptr;
   logic [IDX_W-1:0]  occupancy;
   logic              s_fire;

   // words written but still needed by the current or a later window
   assign occupancy = wr_count - release_base_i;

   // block input while the oldest slot is still needed, and after a full frame
   assign s_ready_o = (occupancy < BUF_DEPTH) && (wr_count < FRAME_WORDS);
   assign s_fire    = s_valid_i && s_ready_o;

   assign wr_en_o    = s_fire;
   assign wr_addr_o  = wr_ptr;
   assign wr_data_o  = s_data_i;
   assign wr_count_o = wr_count;

   ////////////////////
   // write index and circular address

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_count <= '0;
         wr_ptr   <= '0;
      end else if (frame_done_i) begin
         // next frame starts again at index 0, address 0
         wr_count <= '0;
         wr_ptr   <= '0;
      end else if (s_fire) begin
         wr_count <= wr_count + 1'b1;
         if (wr_ptr == BUF_AW'(BUF_DEPTH - 1)) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

endmodule

// File: logic/swu_req_if.sv
`timescale 1ns/1ps

interface swu_req_if;
   import swu_pkg::*;

   logic              req_valid;
   logic              req_ready;
   logic [BUF_AW-1:0] req_addr;
   // final element of the frame
   logic              req_last;

   modport walker (
      output req_valid, req_addr, req_last,
      input  req_ready
   );

   modport reader (
      input  req_valid, req_addr, req_last,
      output req_ready
   );

endinterface

// File: logic/swu_pkg.sv
package swu_pkg;

   // input feature map, one word per channel group
   localparam int IFM_W  = 4;
   localparam int IFM_H  = 4;
   localparam int EFF_CH = 2;

   // square kernel, unit stride, no padding
   localparam int KERNEL = 3;

   localparam int OFM_W = IFM_W - KERNEL + 1;
   localparam int OFM_H = IFM_H - KERNEL + 1;

   localparam int WORD_W = 8;

   // per-frame word counts
   localparam int FRAME_WORDS  = IFM_W * IFM_H * EFF_CH;
   localparam int WINDOW_WORDS = KERNEL * KERNEL * EFF_CH;
   localparam int OUT_WORDS    = OFM_W * OFM_H * WINDOW_WORDS;

   // KERNEL full input rows fit in the line buffer
   localparam int BUF_DEPTH = KERNEL * IFM_W * EFF_CH;
   localparam int BUF_AW    = $clog2(BUF_DEPTH);

   // linear index, must also hold FRAME_WORDS itself
   localparam int IDX_W = $clog2(FRAME_WORDS + 1);

endpackage
